//--- step_motor_cfg.svh
`ifndef STEP_MOTOR_CFG_SVH
`define STEP_MOTOR_CFG_SVH

// number of motor channels
`define SM_MOTOR_NBR 4

// clock-enable ring length in cycles, at least 4 and at least SM_MOTOR_NBR
`define SM_CLK_DIV 8

// entries in the shared acceleration table
`define SM_TABLE_DEPTH 512

// APB address width
`define SM_APB_AW 8

`endif

//--- motor_pkg.sv
`include "step_motor_cfg.svh"

package motor_pkg;

	typedef logic [15:0] step_cnt_t;
	typedef logic signed [15:0] pos_t;

	typedef struct packed {
		logic      start;	// one-cycle pulse
		logic      stop;	// one-cycle pulse
		logic      dir;
		logic [2:0] ms;
		logic      en;
		step_cnt_t steps;
	} motor_cmd_t;

	typedef struct packed {
		logic busy;
		pos_t position;
	} motor_stat_t;

	typedef struct packed {
		logic      drive;
		logic      dir;
		logic [2:0] ms;
		logic      en;
	} motor_pins_t;

	typedef enum logic [1:0] {IDLE, ACCEL, CRUISE, DECEL} chan_state_e;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [`SM_APB_AW-1:0] paddr;
		logic [31:0]           pwdata;
	} apb_req_t;

endpackage

//--- ramp_pkg.sv
`include "step_motor_cfg.svh"

package ramp_pkg;

	// step period in channel ticks
	typedef logic [15:0] spd_t;

	typedef logic [$clog2(`SM_TABLE_DEPTH)-1:0] spd_addr_t;

	typedef struct packed {
		logic      en;
		spd_addr_t addr;
	} spd_rd_req_t;

endpackage

//--- speed_table.sv
`timescale 1ns/1ns
`include "step_motor_cfg.svh"

module speed_table (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   i_rewind,
	input  logic                   i_wr_en,
	input  ramp_pkg::spd_t         i_wr_data,
	input  logic [`SM_CLK_DIV-1:0] i_slot,
	input  ramp_pkg::spd_rd_req_t  i_rd_req [`SM_MOTOR_NBR],
	output ramp_pkg::spd_t         o_rd_data,
	output ramp_pkg::spd_addr_t    o_last_addr
);
	localparam int unsigned depth = `SM_TABLE_DEPTH;
	localparam int unsigned div = `SM_CLK_DIV;
	localparam int unsigned aw = $bits(ramp_pkg::spd_addr_t);

	ramp_pkg::spd_t mem [depth];
	ramp_pkg::spd_rd_req_t req_q;
	logic [aw:0] wr_ptr;
	logic full;

	assign full = (wr_ptr == (aw + 1)'(depth));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ptr <= '0;
			o_last_addr <= '0;
		end else if (i_rewind) begin
			wr_ptr <= '0;
		end else if (i_wr_en && !full) begin
			wr_ptr <= wr_ptr + 1'b1;
			o_last_addr <= wr_ptr[aw-1:0];	// end of acceleration
		end
	end

	// channel m ticks two cycles after slot m-2, so its data lands on its own tick
	always_ff @(posedge clk) begin
		if (!resetn) begin
			req_q <= '0;
		end else begin
			req_q <= '0;
			for (int m = 0; m < `SM_MOTOR_NBR; m++) begin
				if (i_slot[(m + div - 2) % div])
					req_q <= i_rd_req[m];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_wr_en && !full)
			mem[wr_ptr[aw-1:0]] <= i_wr_data;
		if (req_q.en)
			o_rd_data <= mem[req_q.addr];	// shared by all channels
	end

	a_slot_onehot: assert property (@(posedge clk) disable iff (!resetn)
		$onehot(i_slot));

	a_no_write_when_full: assert property (@(posedge clk) disable iff (!resetn)
		i_wr_en |-> !full);

endmodule

//--- motor_channel.sv
`timescale 1ns/1ns

module motor_channel (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   i_tick,
	input  motor_pkg::motor_cmd_t  i_cmd,
	input  ramp_pkg::spd_addr_t    i_last_addr,
	input  ramp_pkg::spd_t         i_rd_data,
	output ramp_pkg::spd_rd_req_t  o_rd_req,
	output motor_pkg::motor_stat_t o_stat,
	output motor_pkg::motor_pins_t o_pins
);
	motor_pkg::chan_state_e state_q;
	motor_pkg::chan_state_e nxt_state;
	motor_pkg::step_cnt_t steps_tgt;
	motor_pkg::step_cnt_t step_cnt;
	motor_pkg::step_cnt_t rem;
	motor_pkg::step_cnt_t mirror;
	motor_pkg::step_cnt_t last_ext;
	motor_pkg::step_cnt_t idx;
	motor_pkg::pos_t pos_q;
	ramp_pkg::spd_t tmr;
	ramp_pkg::spd_t period;
	ramp_pkg::spd_t cur_period;
	ramp_pkg::spd_rd_req_t rd_req_q;
	logic drive_q;
	logic halt_q;
	logic move_dir;
	logic busy;
	logic fire;

	assign busy = (state_q != motor_pkg::IDLE);
	assign cur_period = (tmr == 16'd1) ? i_rd_data : period;	// fresh entry on first tick
	assign fire = (tmr >= cur_period);
	assign rem = steps_tgt - step_cnt - 16'd1;	// steps left after this pulse
	assign mirror = rem - 16'd1;
	assign last_ext = motor_pkg::step_cnt_t'(i_last_addr);

	// ramp index is the smallest of steps done, steps to go and table end
	always_comb begin
		idx = step_cnt;
		if (mirror < idx)
			idx = mirror;
		if (last_ext < idx)
			idx = last_ext;
		if (idx == last_ext)
			nxt_state = motor_pkg::CRUISE;
		else if (step_cnt <= mirror)
			nxt_state = motor_pkg::ACCEL;
		else
			nxt_state = motor_pkg::DECEL;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state_q <= motor_pkg::IDLE;
			steps_tgt <= '0;
			step_cnt <= '0;
			pos_q <= '0;
			tmr <= '0;
			period <= '0;
			rd_req_q <= '0;
			drive_q <= 1'b0;
			halt_q <= 1'b0;
			move_dir <= 1'b0;
		end else if (i_cmd.start && !busy && i_cmd.steps != '0) begin
			state_q <= motor_pkg::ACCEL;
			steps_tgt <= i_cmd.steps;
			step_cnt <= '0;
			tmr <= '1;	// first pulse on next tick
			rd_req_q <= '{en: 1'b1, addr: '0};
			halt_q <= 1'b0;
			move_dir <= i_cmd.dir;
		end else if (busy) begin
			if (i_cmd.stop)
				halt_q <= 1'b1;
			if (i_tick) begin
				if (halt_q) begin
					state_q <= motor_pkg::IDLE;	// after current pulse
					drive_q <= 1'b0;
					rd_req_q.en <= 1'b0;
					halt_q <= 1'b0;
				end else begin
					drive_q <= fire;
					if (tmr == 16'd1)
						period <= i_rd_data;
					if (fire) begin
						step_cnt <= step_cnt + 16'd1;
						pos_q <= move_dir ? pos_q + 16'sd1 : pos_q - 16'sd1;
						tmr <= 16'd1;
						if (rem == '0) begin
							halt_q <= 1'b1;	// last step
						end else begin
							state_q <= nxt_state;
							rd_req_q.addr <= ramp_pkg::spd_addr_t'(idx);
						end
					end else begin
						tmr <= tmr + 16'd1;
					end
				end
			end
		end
	end

	assign o_rd_req = rd_req_q;
	assign o_stat = '{busy: busy, position: pos_q};
	assign o_pins = '{
		drive: drive_q,
		dir:   busy ? move_dir : i_cmd.dir,
		ms:    i_cmd.ms,
		en:    i_cmd.en
	};

	a_no_drive_idle: assert property (@(posedge clk) disable iff (!resetn)
		state_q == motor_pkg::IDLE |-> !drive_q);

	a_steps_bounded: assert property (@(posedge clk) disable iff (!resetn)
		step_cnt <= steps_tgt);

endmodule

//--- apb_motor_regs.sv
`timescale 1ns/1ns
`include "step_motor_cfg.svh"

module apb_motor_regs (
	input  logic                   clk,
	input  logic                   resetn,
	input  motor_pkg::apb_req_t    i_apb,
	output logic [31:0]            o_prdata,
	output logic                   o_pslverr,
	input  motor_pkg::motor_stat_t i_stat [`SM_MOTOR_NBR],
	output motor_pkg::motor_cmd_t  o_cmd [`SM_MOTOR_NBR],
	output logic                   o_tbl_rewind,
	output logic                   o_tbl_wr_en,
	output ramp_pkg::spd_t         o_tbl_data
);
	localparam int unsigned nbr = `SM_MOTOR_NBR;

	motor_pkg::step_cnt_t steps_q [nbr];
	logic [2:0] ms_q [nbr];
	logic [nbr-1:0] hit;
	logic [nbr-1:0] en_q;
	logic [nbr-1:0] dir_q;
	logic [nbr-1:0] start_q;
	logic [nbr-1:0] stop_q;
	logic [`SM_APB_AW-5:0] region;
	logic [3:0] offs;
	logic access;
	logic wr;
	logic err;
	logic any_busy;

	assign region = i_apb.paddr[`SM_APB_AW-1:4];	// 0 is the table, m+1 is motor m
	assign offs = i_apb.paddr[3:0];
	assign access = i_apb.psel & i_apb.penable;	// no wait states
	assign wr = access & i_apb.pwrite & ~err;

	always_comb begin
		any_busy = 1'b0;
		for (int m = 0; m < nbr; m++) begin
			hit[m] = (32'(region) == m + 1);
			any_busy |= i_stat[m].busy;
		end
	end

	always_comb begin
		err = 1'b0;
		if (offs[1:0] != 2'b00)
			err = 1'b1;
		else if (region == '0)
			err = offs[3] | (i_apb.pwrite & any_busy);	// table locked while moving
		else if (hit == '0)
			err = 1'b1;
	end

	assign o_pslverr = access & err;

	always_comb begin
		o_prdata = '0;
		for (int m = 0; m < nbr; m++) begin
			if (hit[m]) begin
				case (offs)
					4'h0: o_prdata = {16'b0, steps_q[m]};
					4'h4: o_prdata = {27'b0, ms_q[m], dir_q[m], en_q[m]};
					4'hC: o_prdata = {15'b0, i_stat[m].busy, i_stat[m].position};
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_tbl_rewind <= 1'b0;
			o_tbl_wr_en <= 1'b0;
			en_q <= '0;
			dir_q <= '0;
			start_q <= '0;
			stop_q <= '0;
			for (int m = 0; m < nbr; m++) begin
				steps_q[m] <= '0;
				ms_q[m] <= '0;
			end
		end else begin
			o_tbl_rewind <= wr && region == '0 && offs == 4'h0;
			o_tbl_wr_en <= wr && region == '0 && offs == 4'h4;
			for (int m = 0; m < nbr; m++) begin
				start_q[m] <= wr && hit[m] && offs == 4'h8 && i_apb.pwdata[0];	// pulse
				stop_q[m] <= wr && hit[m] && offs == 4'h8 && i_apb.pwdata[1];
				if (wr && hit[m] && offs == 4'h0)
					steps_q[m] <= i_apb.pwdata[15:0];
				if (wr && hit[m] && offs == 4'h4) begin
					en_q[m] <= i_apb.pwdata[0];
					dir_q[m] <= i_apb.pwdata[1];
					ms_q[m] <= i_apb.pwdata[4:2];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr && region == '0 && offs == 4'h4)
			o_tbl_data <= i_apb.pwdata[15:0];
	end

	always_comb begin
		for (int m = 0; m < nbr; m++) begin
			o_cmd[m] = '{
				start: start_q[m],
				stop:  stop_q[m],
				dir:   dir_q[m],
				ms:    ms_q[m],
				en:    en_q[m],
				steps: steps_q[m]
			};
		end
	end

	a_penable_needs_psel: assert property (@(posedge clk) disable iff (!resetn)
		i_apb.penable |-> i_apb.psel);

endmodule

//--- step_motor.sv
`timescale 1ns/1ns
`include "step_motor_cfg.svh"

module step_motor (
	input  logic                   clk,
	input  logic                   resetn,
	input  motor_pkg::apb_req_t    i_apb,
	output logic [31:0]            o_prdata,
	output logic                   o_pslverr,
	output motor_pkg::motor_pins_t o_pins [`SM_MOTOR_NBR]
);
	motor_pkg::motor_cmd_t cmd [`SM_MOTOR_NBR];
	motor_pkg::motor_stat_t stat [`SM_MOTOR_NBR];
	ramp_pkg::spd_rd_req_t rd_req [`SM_MOTOR_NBR];
	ramp_pkg::spd_t rd_data;
	ramp_pkg::spd_t tbl_data;
	ramp_pkg::spd_addr_t last_addr;
	logic tbl_rewind;
	logic tbl_wr_en;
	logic [`SM_CLK_DIV-1:0] ring;

	// one-hot clock-enable ring, bit i is channel i's tick
	always_ff @(posedge clk) begin
		if (!resetn)
			ring <= `SM_CLK_DIV'(1);
		else
			ring <= {ring[`SM_CLK_DIV-2:0], ring[`SM_CLK_DIV-1]};
	end

	speed_table speed_table_i (
		.clk         (clk),
		.resetn      (resetn),
		.i_rewind    (tbl_rewind),
		.i_wr_en     (tbl_wr_en),
		.i_wr_data   (tbl_data),
		.i_slot      (ring),
		.i_rd_req    (rd_req),
		.o_rd_data   (rd_data),
		.o_last_addr (last_addr)
	);

	apb_motor_regs apb_motor_regs_i (
		.clk          (clk),
		.resetn       (resetn),
		.i_apb        (i_apb),
		.o_prdata     (o_prdata),
		.o_pslverr    (o_pslverr),
		.i_stat       (stat),
		.o_cmd        (cmd),
		.o_tbl_rewind (tbl_rewind),
		.o_tbl_wr_en  (tbl_wr_en),
		.o_tbl_data   (tbl_data)
	);

	for (genvar i = 0; i < `SM_MOTOR_NBR; i++) begin : g_chan
		motor_channel motor_channel_i (
			.clk         (clk),
			.resetn      (resetn),
			.i_tick      (ring[i]),
			.i_cmd       (cmd[i]),
			.i_last_addr (last_addr),
			.i_rd_data   (rd_data),
			.o_rd_req    (rd_req[i]),
			.o_stat      (stat[i]),
			.o_pins      (o_pins[i])
		);
	end

endmodule

//--- tb_step_motor.sv
`timescale 1ns/1ns
`include "step_motor_cfg.svh"

module tb_step_motor;
	localparam int nbr = `SM_MOTOR_NBR;

	// one move line of the stim file
	typedef struct packed {
		logic [31:0] steps;
		logic [31:0] ctl;
		logic [31:0] exp_a;	// expected pulses, or stop point
		logic [31:0] exp_b;	// expected position, or expected ms
	} move_t;

	logic clk;
	logic resetn;
	motor_pkg::apb_req_t apb;
	logic [31:0] prdata;
	logic pslverr;
	motor_pkg::motor_pins_t pins [nbr];

	logic [31:0] stim [64];
	int sp = 0;
	move_t mv [nbr];
	int unsigned cyc = 0;
	int unsigned pulse_cnt [nbr] = '{default: 0};
	int unsigned dir_hi_cnt [nbr] = '{default: 0};
	int unsigned base_cnt [nbr];
	int unsigned base_dir [nbr];
	logic drive_prev [nbr] = '{default: 1'b0};
	int unsigned edge_cyc0 [$];	// cycle of each motor 0 pulse

	step_motor step_motor_i (
		.clk       (clk),
		.resetn    (resetn),
		.i_apb     (apb),
		.o_prdata  (prdata),
		.o_pslverr (pslverr),
		.o_pins    (pins)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// pulse edges seen away from the active edge
	always @(negedge clk) begin
		for (int m = 0; m < nbr; m++) begin
			drive_prev[m] <= pins[m].drive;
			if (pins[m].drive && !drive_prev[m]) begin
				pulse_cnt[m] <= pulse_cnt[m] + 1;
				if (pins[m].dir)
					dir_hi_cnt[m] <= dir_hi_cnt[m] + 1;
				if (m == 0)
					edge_cyc0.push_back(cyc);
			end
		end
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	function automatic logic [31:0] next_word();
		next_word = stim[sp];
		sp++;
	endfunction

	function automatic logic [`SM_APB_AW-1:0] motor_addr(input int m, input logic [3:0] offs);
		return `SM_APB_AW'(16 * (m + 1)) | `SM_APB_AW'(offs);
	endfunction

	task automatic apb_xfer(input logic wr, input logic [`SM_APB_AW-1:0] addr,
		input logic [31:0] wdata, input logic exp_err, output logic [31:0] rdata);
		int unsigned gap;
		gap = $urandom % 3;
		repeat (gap) @(posedge clk);
		@(posedge clk);
		#1;
		apb.psel = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite = wr;
		apb.paddr = addr;
		apb.pwdata = wdata;
		@(posedge clk);
		#1;
		apb.penable = 1'b1;	// access phase, PREADY always high
		@(negedge clk);
		rdata = prdata;
		check($sformatf("pslverr at 0x%h", addr), 32'(pslverr), 32'(exp_err));
		@(posedge clk);
		#1;
		apb = '0;
	endtask

	task automatic wait_idle(input int m);
		logic [31:0] st;
		int polls;
		st = 32'h1_0000;
		for (polls = 0; polls < 4000 && st[16]; polls++)
			apb_xfer(1'b0, motor_addr(m, 4'hC), '0, 1'b0, st);
		if (st[16])
			fail_run($sformatf("motor %0d stayed busy past the timeout", m));
	endtask

	task automatic load_move(output int m);
		logic [31:0] rd;
		m = int'(next_word());
		mv[m].steps = next_word();
		mv[m].ctl = next_word();
		mv[m].exp_a = next_word();
		mv[m].exp_b = next_word();
		apb_xfer(1'b1, motor_addr(m, 4'h0), mv[m].steps, 1'b0, rd);
		apb_xfer(1'b1, motor_addr(m, 4'h4), mv[m].ctl, 1'b0, rd);
		apb_xfer(1'b0, motor_addr(m, 4'h0), '0, 1'b0, rd);
		check($sformatf("motor %0d steps register", m), rd, {16'd0, mv[m].steps[15:0]});
	endtask

	task automatic start_move(input int m);
		logic [31:0] st;
		base_cnt[m] = pulse_cnt[m];
		base_dir[m] = dir_hi_cnt[m];
		apb_xfer(1'b1, motor_addr(m, 4'h8), 32'h1, 1'b0, st);
		apb_xfer(1'b0, motor_addr(m, 4'hC), '0, 1'b0, st);
		check($sformatf("motor %0d busy", m), 32'(st[16]), 32'd1);
	endtask

	task automatic finish_move(input int m);
		logic [31:0] st;
		wait_idle(m);
		check($sformatf("motor %0d pulses", m), pulse_cnt[m] - base_cnt[m], mv[m].exp_a);
		check($sformatf("motor %0d pulses with dir high", m), dir_hi_cnt[m] - base_dir[m],
			mv[m].ctl[1] ? mv[m].exp_a : 32'd0);
		apb_xfer(1'b0, motor_addr(m, 4'hC), '0, 1'b0, st);
		check($sformatf("motor %0d position", m), {16'd0, st[15:0]},
			{16'd0, mv[m].exp_b[15:0]});
	endtask

	initial begin
		int ma;
		int mb;
		int n;
		logic [31:0] w;
		clk = 1'b0;
		resetn = 1'b0;
		apb = '0;
		void'($urandom(32'h4b67));
		$readmemh("step_motor_stim.txt", stim);
		repeat (2) @(posedge clk);
		#1;
		resetn = 1'b1;

		check("pslverr", 32'(pslverr), 32'd0);
		for (int m = 0; m < nbr; m++) begin
			check($sformatf("pins[%0d].drive", m), 32'(pins[m].drive), 32'd0);
			check($sformatf("pins[%0d].en", m), 32'(pins[m].en), 32'd0);
			apb_xfer(1'b0, motor_addr(m, 4'hC), '0, 1'b0, w);
			check($sformatf("motor %0d status", m), w, 32'd0);
		end

		n = int'(next_word());
		apb_xfer(1'b1, 8'h00, '0, 1'b0, w);	// rewind
		for (int k = 0; k < n; k++)
			apb_xfer(1'b1, 8'h04, next_word(), 1'b0, w);

		// forward move with ramp timing
		load_move(ma);
		start_move(ma);
		finish_move(ma);
		n = int'(next_word());
		for (int k = 0; k < n; k++)
			check($sformatf("motor 0 interval %0d", k),
				edge_cyc0[base_cnt[0] + k + 1] - edge_cyc0[base_cnt[0] + k], next_word());

		// reverse move
		load_move(ma);
		start_move(ma);
		finish_move(ma);

		// two motors at once
		load_move(ma);
		load_move(mb);
		start_move(ma);
		start_move(mb);
		finish_move(ma);
		finish_move(mb);

		// long move cut short by a stop
		load_move(ma);
		check("long move ms pins", 32'(pins[ma].ms), mv[ma].exp_b);
		check("long move en pin", 32'(pins[ma].en), 32'd1);
		start_move(ma);
		for (n = 0; n < 20000 && pulse_cnt[ma] - base_cnt[ma] < mv[ma].exp_a; n++)
			@(posedge clk);
		if (pulse_cnt[ma] - base_cnt[ma] < mv[ma].exp_a)
			fail_run("long move did not reach its stop point in time");
		apb_xfer(1'b1, 8'h04, 32'h0009, 1'b1, w);	// table locked while busy
		apb_xfer(1'b0, 8'h50, '0, 1'b1, w);	// unmapped
		apb_xfer(1'b1, motor_addr(ma, 4'h8), 32'h2, 1'b0, w);
		wait_idle(ma);
		apb_xfer(1'b0, motor_addr(ma, 4'hC), '0, 1'b0, w);
		check("long move position", {16'd0, w[15:0]}, pulse_cnt[ma] - base_cnt[ma]);
		check("long move stopped early",
			32'(pulse_cnt[ma] - base_cnt[ma] < mv[ma].steps), 32'd1);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- step_motor_stim.txt
// hex words: table length, then table entries (step period in ticks)
// move lines: motor, steps, control, expected pulses, expected position
6
c a 8 6 5 4
0 0014 03 0014 0014  // motor 0 forward
4 60 50 40 30        // count, then first accel intervals in cycles
0 0007 01 0007 000d  // motor 0 reverse
1 0009 03 0009 0009  // motor 1, runs with motor 2
2 0005 01 0005 fffb  // motor 2 reverse
3 03e8 17 000a 0005  // long move: stop point in pulses, expected ms

//--- compile.f
+incdir+.
motor_pkg.sv
ramp_pkg.sv
speed_table.sv
motor_channel.sv
apb_motor_regs.sv
step_motor.sv
tb_step_motor.sv

//--- Makefile
TOP := tb_step_motor

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
